// File: common/kernel_defines.svh
// Width, depth and timing constants for the kernel control block.
// Included by the package and by any RTL file that sizes logic from them.

`ifndef KERNEL_DEFINES_SVH
`define KERNEL_DEFINES_SVH

// ------------------------------
// Datapath widths
// ------------------------------
`define KERNEL_ADDR_WIDTH 32
`define KERNEL_DATA_WIDTH 32

// Setup and bundles engines, round-robin assumes exactly two
`define KERNEL_NUM_REQUESTORS 2

// ------------------------------
// Request FIFO sizing
// ------------------------------
`define KERNEL_REQ_FIFO_DEPTH 8
// Occupancy where grants stop
`define KERNEL_REQ_FIFO_PROG_FULL 6

// Consecutive cycles a done condition must hold
`define KERNEL_DONE_HOLD_CYCLES 16

`endif

// File: common/kernel_pkg.sv
// Shared types for the kernel control block: memory command, requestor
// index, kernel descriptor and the request/response packets.
// Imported by wildcard in the header of each RTL module.

`include "kernel_defines.svh"

package kernel_pkg;

  // ------------------------------
  // Command and requestor index
  // ------------------------------
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } mem_cmd_t;

  typedef logic [$clog2(`KERNEL_NUM_REQUESTORS)-1:0] requestor_id_t;

  // Requestor slots on the arbiter
  localparam requestor_id_t req_id_setup   = 1'b0;
  localparam requestor_id_t req_id_bundles = 1'b1;

  // Counter width for the done hold, saturates at the hold length
  localparam int done_count_width = $clog2(`KERNEL_DONE_HOLD_CYCLES + 1);

  // ------------------------------
  // Packets
  // ------------------------------
  typedef struct packed {
    logic [`KERNEL_ADDR_WIDTH-1:0] graph_base;
    logic [`KERNEL_DATA_WIDTH-1:0] vertex_count;
    logic [`KERNEL_DATA_WIDTH-1:0] edge_count;
  } kernel_descriptor_t;

  typedef struct packed {
    mem_cmd_t                      cmd;
    requestor_id_t                 id;
    logic [`KERNEL_ADDR_WIDTH-1:0] address;
    logic [`KERNEL_DATA_WIDTH-1:0] data;
  } mem_request_t;

  typedef struct packed {
    requestor_id_t                 id;
    mem_cmd_t                      cmd;
    logic [`KERNEL_DATA_WIDTH-1:0] data;
  } mem_response_t;

endpackage : kernel_pkg

// File: hw/decode/descriptor_stage.sv
// Two-stage register pipeline for the kernel descriptor. One shared input
// stage, then a private output copy per requestor engine.

`timescale 1ns/10ps

module descriptor_stage
  import kernel_pkg::*;
(
  input  logic               ap_clk,
  input  logic               areset_control,
  input  logic               descriptor_valid,
  input  kernel_descriptor_t descriptor,
  output logic               setup_descriptor_valid,
  output kernel_descriptor_t setup_descriptor,
  output logic               bundles_descriptor_valid,
  output kernel_descriptor_t bundles_descriptor
);

  // Input stage
  logic               desc_valid_q;
  kernel_descriptor_t desc_q;

  // Valid path, cleared by reset
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_valid_q             <= 1'b0;
      setup_descriptor_valid   <= 1'b0;
      bundles_descriptor_valid <= 1'b0;
    end else begin
      desc_valid_q             <= descriptor_valid;
      setup_descriptor_valid   <= desc_valid_q;
      bundles_descriptor_valid <= desc_valid_q;
    end
  end

  // Payload path
  // Separate copies so each engine gets its own local fan-out
  always_ff @(posedge ap_clk) begin
    desc_q             <= descriptor;
    setup_descriptor   <= desc_q;
    bundles_descriptor <= desc_q;
  end

endmodule : descriptor_stage

// File: hw/execute/request_fifo.sv
// Show-ahead request FIFO between the arbiter and the memory port.
// The head entry is on rd_data whenever empty is low; rd_en pops it.

`timescale 1ns/10ps

`include "kernel_defines.svh"

module request_fifo
  import kernel_pkg::*;
(
  input  logic         ap_clk,
  input  logic         areset_control,
  input  logic         wr_en,
  input  mem_request_t wr_data,
  input  logic         rd_en,
  output mem_request_t rd_data,
  output logic         empty,
  output logic         prog_full
);

  localparam int depth   = `KERNEL_REQ_FIFO_DEPTH;
  localparam int ptr_w   = $clog2(depth);
  localparam int count_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0]   ptr_t;
  typedef logic [count_w-1:0] count_t;

  mem_request_t mem [depth];
  ptr_t         wr_ptr;
  ptr_t         rd_ptr;
  count_t       count;
  logic         full;

  // Storage, no reset on payload
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head visible without a read
  assign rd_data   = mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == count_t'(depth));
  assign prog_full = (count >= count_t'(`KERNEL_REQ_FIFO_PROG_FULL));

  fifo_no_overflow_a : assert property (@(posedge ap_clk) disable iff (areset_control)
    wr_en |-> !full)
    else $error("request FIFO written while full");

  fifo_no_underflow_a : assert property (@(posedge ap_clk) disable iff (areset_control)
    rd_en |-> !empty)
    else $error("request FIFO read while empty");

endmodule : request_fifo

// File: hw/execute/request_arbiter.sv
// Round-robin arbiter between the setup and bundles requestors. Grants go
// out in the cycle a request is seen, the granted packet is tagged with its
// requestor id and queued; the queue head is issued whenever memory is ready.

`timescale 1ns/10ps

module request_arbiter
  import kernel_pkg::*;
(
  input  logic         ap_clk,
  input  logic         areset_control,
  input  logic         setup_req_valid,
  input  mem_request_t setup_req,
  input  logic         bundles_req_valid,
  input  mem_request_t bundles_req,
  input  logic         mem_ready,
  output logic         setup_grant,
  output logic         bundles_grant,
  output logic         mem_req_valid,
  output mem_request_t mem_req,
  output logic         fifo_empty
);

  requestor_id_t last_grant;
  logic          prefer_bundles;
  logic          fifo_wr_en;
  logic          fifo_rd_en;
  logic          fifo_prog_full;
  mem_request_t  fifo_wr_data;
  mem_request_t  fifo_rd_data;

  // ------------------------------
  // Grant
  // ------------------------------
  // On a tie, favour whoever was not served last
  assign prefer_bundles = (last_grant == req_id_setup);

  always_comb begin
    setup_grant   = 1'b0;
    bundles_grant = 1'b0;
    // Queue near full, hold everyone off
    if (!fifo_prog_full) begin
      if (setup_req_valid && bundles_req_valid) begin
        setup_grant   = !prefer_bundles;
        bundles_grant = prefer_bundles;
      end else begin
        setup_grant   = setup_req_valid;
        bundles_grant = bundles_req_valid;
      end
    end
  end

  // Winner's packet, id overwritten with the granted slot
  always_comb begin
    fifo_wr_data    = bundles_grant ? bundles_req : setup_req;
    fifo_wr_data.id = bundles_grant ? req_id_bundles : req_id_setup;
  end

  assign fifo_wr_en = setup_grant | bundles_grant;

  // Starts on bundles so setup wins the first tie
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      last_grant <= req_id_bundles;
    end else if (fifo_wr_en) begin
      last_grant <= bundles_grant ? req_id_bundles : req_id_setup;
    end
  end

  // ------------------------------
  // Queue and memory issue
  // ------------------------------
  request_fifo request_fifo_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (fifo_wr_en),
    .wr_data       (fifo_wr_data),
    .rd_en         (fifo_rd_en),
    .rd_data       (fifo_rd_data),
    .empty         (fifo_empty),
    .prog_full     (fifo_prog_full)
  );

  // Head leaves on every ready cycle, grant order is kept
  assign mem_req_valid = mem_ready & ~fifo_empty;
  assign mem_req       = fifo_rd_data;
  assign fifo_rd_en    = mem_req_valid;

  // Grants are one-hot per cycle
  grant_onehot_a : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(setup_grant && bundles_grant))
    else $error("setup and bundles granted together");

  // Back-pressure from the queue level stops all grants
  grant_backpressure_a : assert property (@(posedge ap_clk) disable iff (areset_control)
    fifo_prog_full |-> !(setup_grant || bundles_grant))
    else $error("grant issued while request FIFO prog_full");

endmodule : request_arbiter

// File: hw/result/response_router.sv
// Routes each memory response to the requestor named by its id, one cycle
// after it arrives. Responses are always accepted.

`timescale 1ns/10ps

module response_router
  import kernel_pkg::*;
(
  input  logic          ap_clk,
  input  logic          areset_control,
  input  logic          mem_resp_valid,
  input  mem_response_t mem_resp,
  output logic          setup_resp_valid,
  output mem_response_t setup_resp,
  output logic          bundles_resp_valid,
  output mem_response_t bundles_resp
);

  mem_response_t resp_q;

  // Payload register, shared by both outputs
  always_ff @(posedge ap_clk) begin
    resp_q <= mem_resp;
  end

  // Id decode, exactly one valid per response
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup_resp_valid   <= 1'b0;
      bundles_resp_valid <= 1'b0;
    end else begin
      setup_resp_valid   <= mem_resp_valid && (mem_resp.id == req_id_setup);
      bundles_resp_valid <= mem_resp_valid && (mem_resp.id == req_id_bundles);
    end
  end

  assign setup_resp   = resp_q;
  assign bundles_resp = resp_q;

endmodule : response_router

// File: hw/result/done_monitor.sv
// Done and flush qualification. Each requestor done level, gated with an
// empty request FIFO, must hold for KERNEL_DONE_HOLD_CYCLES consecutive
// cycles before its output rises; any break clears it on the next edge.

`timescale 1ns/10ps

`include "kernel_defines.svh"

module done_monitor
  import kernel_pkg::*;
(
  input  logic ap_clk,
  input  logic areset_control,
  input  logic setup_done,
  input  logic bundles_done,
  input  logic fifo_empty,
  output logic done_out,
  output logic flush_out
);

  localparam int hold_cycles = `KERNEL_DONE_HOLD_CYCLES;

  typedef logic [done_count_width-1:0] count_t;

  // Slot 0 drives done, slot 1 drives flush
  logic   hold_cond [2];
  count_t hold_count [2];
  logic   hold_reached [2];

  assign hold_cond[0] = setup_done & fifo_empty;
  assign hold_cond[1] = bundles_done & fifo_empty;

  // ------------------------------
  // Saturating hold counters
  // ------------------------------
  for (genvar i = 0; i < 2; i++) begin : g_hold
    always_ff @(posedge ap_clk) begin
      if (areset_control) begin
        hold_count[i]   <= '0;
        hold_reached[i] <= 1'b0;
      end else if (!hold_cond[i]) begin
        // Condition broke, start over
        hold_count[i]   <= '0;
        hold_reached[i] <= 1'b0;
      end else begin
        if (hold_count[i] != count_t'(hold_cycles)) begin
          hold_count[i] <= hold_count[i] + 1'b1;
        end
        hold_reached[i] <= (hold_count[i] == count_t'(hold_cycles));
      end
    end
  end

  assign done_out  = hold_reached[0];
  assign flush_out = hold_reached[1];

  // Done must not be reported while requests are still queued
  done_fifo_empty_a : assert property (@(posedge ap_clk) disable iff (areset_control)
    done_out |-> fifo_empty)
    else $error("done_out high with request FIFO not empty");

endmodule : done_monitor

// File: hw/kernel_control.sv
// Kernel control block of the graph compute unit. Stages the descriptor to
// the setup and bundles engines, arbitrates their memory requests into one
// port, routes responses back and reports done/flush.

`timescale 1ns/10ps

module kernel_control
  import kernel_pkg::*;
(
  input  logic               ap_clk,
  input  logic               areset_control,
  input  logic               descriptor_valid,
  input  kernel_descriptor_t descriptor,
  input  logic               setup_req_valid,
  input  mem_request_t       setup_req,
  input  logic               bundles_req_valid,
  input  mem_request_t       bundles_req,
  input  logic               mem_ready,
  input  logic               mem_resp_valid,
  input  mem_response_t      mem_resp,
  input  logic               setup_done,
  input  logic               bundles_done,
  output logic               setup_descriptor_valid,
  output kernel_descriptor_t setup_descriptor,
  output logic               bundles_descriptor_valid,
  output kernel_descriptor_t bundles_descriptor,
  output logic               setup_grant,
  output logic               bundles_grant,
  output logic               mem_req_valid,
  output mem_request_t       mem_req,
  output logic               setup_resp_valid,
  output mem_response_t      setup_resp,
  output logic               bundles_resp_valid,
  output mem_response_t      bundles_resp,
  output logic               done_out,
  output logic               flush_out
);

  // Local reset copy, everything inside runs one cycle behind
  logic areset_kernel;
  // Request FIFO drained, feeds the done hold
  logic fifo_empty;

  always_ff @(posedge ap_clk) begin
    areset_kernel <= areset_control;
  end

  // ------------------------------
  // Decode
  // ------------------------------
  descriptor_stage descriptor_stage_i (
    .ap_clk                  (ap_clk),
    .areset_control          (areset_kernel),
    .descriptor_valid        (descriptor_valid),
    .descriptor              (descriptor),
    .setup_descriptor_valid  (setup_descriptor_valid),
    .setup_descriptor        (setup_descriptor),
    .bundles_descriptor_valid(bundles_descriptor_valid),
    .bundles_descriptor      (bundles_descriptor)
  );

  // ------------------------------
  // Execute
  // ------------------------------
  request_arbiter request_arbiter_i (
    .ap_clk           (ap_clk),
    .areset_control   (areset_kernel),
    .setup_req_valid  (setup_req_valid),
    .setup_req        (setup_req),
    .bundles_req_valid(bundles_req_valid),
    .bundles_req      (bundles_req),
    .mem_ready        (mem_ready),
    .setup_grant      (setup_grant),
    .bundles_grant    (bundles_grant),
    .mem_req_valid    (mem_req_valid),
    .mem_req          (mem_req),
    .fifo_empty       (fifo_empty)
  );

  // ------------------------------
  // Result
  // ------------------------------
  response_router response_router_i (
    .ap_clk            (ap_clk),
    .areset_control    (areset_kernel),
    .mem_resp_valid    (mem_resp_valid),
    .mem_resp          (mem_resp),
    .setup_resp_valid  (setup_resp_valid),
    .setup_resp        (setup_resp),
    .bundles_resp_valid(bundles_resp_valid),
    .bundles_resp      (bundles_resp)
  );

  done_monitor done_monitor_i (
    .ap_clk        (ap_clk),
    .areset_control(areset_kernel),
    .setup_done    (setup_done),
    .bundles_done  (bundles_done),
    .fifo_empty    (fifo_empty),
    .done_out      (done_out),
    .flush_out     (flush_out)
  );

endmodule : kernel_control

// File: verification/kernel_control_tb.sv
// Testbench for the kernel control block. Applies a table of memory
// requests in batches, models memory with a fixed read latency and checks
// descriptor staging, request order, round-robin, back-pressure, routing and done.

`timescale 1ns/10ps

module kernel_control_tb
  import kernel_pkg::*;
();

  localparam int num_rows = 22;
  localparam int read_latency = 3;
  localparam logic [31:0] resp_pattern = 32'h5a5a_5a5a;

  typedef struct {
    logic     req;
    mem_cmd_t cmd;
    logic [31:0] addr;
    logic [31:0] data;
    int       batch;
    int       ready_low;
  } row_t;

  logic ap_clk, areset_control, descriptor_valid, mem_ready, mem_resp_valid;
  logic setup_req_valid, bundles_req_valid, setup_done, bundles_done;
  kernel_descriptor_t descriptor, setup_descriptor, bundles_descriptor;
  mem_request_t setup_req, bundles_req, mem_req;
  mem_response_t mem_resp, setup_resp, bundles_resp;
  logic setup_descriptor_valid, bundles_descriptor_valid, setup_grant, bundles_grant;
  logic mem_req_valid, setup_resp_valid, bundles_resp_valid, done_out, flush_out;

  // Next values, applied just after the rising edge
  logic desc_valid_nx, mem_ready_nx, setup_done_nx, bundles_done_nx;
  kernel_descriptor_t desc_nx;
  kernel_descriptor_t exp_desc;

  row_t          table_rows [num_rows];
  mem_request_t  setup_q[$], bundles_q[$], exp_q[$];
  mem_response_t pend_resp[$];
  int            pend_due[$];
  mem_response_t exp_resp;
  logic          exp_resp_valid, setup_granted, bundles_granted, have_last;
  requestor_id_t last_id;
  int            errors, cyc, queued;
  integer        seed = 32'hdc78;

  kernel_control kernel_control_i (.*);

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // Watchdog sized from the table length
  initial begin
    #((num_rows * 64 + 400) * 4);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------
  // Per-cycle drive and sample
  // ------------------------------
  task automatic drive_inputs();
    // Response captured on this edge shows up at the router next
    exp_resp_valid = mem_resp_valid;
    exp_resp = mem_resp;
    if (setup_granted) void'(setup_q.pop_front());
    if (bundles_granted) void'(bundles_q.pop_front());
    setup_req_valid = (setup_q.size() > 0);
    setup_req = setup_req_valid ? setup_q[0] : '0;
    bundles_req_valid = (bundles_q.size() > 0);
    bundles_req = bundles_req_valid ? bundles_q[0] : '0;
    mem_ready = mem_ready_nx;
    descriptor_valid = desc_valid_nx;
    descriptor = desc_nx;
    setup_done = setup_done_nx;
    bundles_done = bundles_done_nx;
    mem_resp_valid = 1'b0;
    if (pend_due.size() > 0 && pend_due[0] == cyc) begin
      void'(pend_due.pop_front());
      mem_resp = pend_resp.pop_front();
      mem_resp_valid = 1'b1;
    end
    cyc++;
  endtask

  task automatic sample_and_check();
    mem_request_t  pkt;
    mem_response_t rsp;
    setup_granted = setup_grant;
    bundles_granted = bundles_grant;
    if (setup_grant && bundles_grant) begin
      $display("Both requestors granted in the same cycle");
      errors++;
    end
    if ((setup_grant || bundles_grant) && queued >= 6) begin
      $display("Grant given with 6 requests already queued");
      errors++;
    end
    if ((setup_req_valid || bundles_req_valid) && queued < 6 &&
        !setup_grant && !bundles_grant) begin
      $display("Pending request was not granted in the same cycle");
      errors++;
    end
    // Memory issue, head of the queue in grant order
    if (mem_req_valid) begin
      if (!mem_ready) begin
        $display("Request issued while memory not ready");
        errors++;
      end
      if (exp_q.size() == 0) begin
        $display("Request issued with nothing queued");
        errors++;
      end else begin
        pkt = exp_q.pop_front();
        check_value("mem_req", mem_req, pkt);
        queued--;
        if (pkt.cmd == cmd_read) begin
          rsp.id = pkt.id;
          rsp.cmd = cmd_read;
          rsp.data = pkt.address ^ resp_pattern;
          pend_resp.push_back(rsp);
          pend_due.push_back(cyc + read_latency);
        end
      end
    end
    if (setup_grant ^ bundles_grant) begin
      pkt = setup_grant ? setup_req : bundles_req;
      pkt.id = setup_grant ? 1'b0 : 1'b1;
      // On a tie the one not served last must win
      if (setup_req_valid && bundles_req_valid && have_last && pkt.id == last_id) begin
        $display("Round-robin broken, same requestor granted twice on a tie");
        errors++;
      end
      last_id = pkt.id;
      have_last = 1'b1;
      exp_q.push_back(pkt);
      queued++;
    end
    // Routing by id
    check_value("setup_resp_valid", setup_resp_valid, exp_resp_valid && exp_resp.id == 1'b0);
    check_value("bundles_resp_valid", bundles_resp_valid, exp_resp_valid && exp_resp.id == 1'b1);
    if (setup_resp_valid) check_value("setup_resp", setup_resp, exp_resp);
    if (bundles_resp_valid) check_value("bundles_resp", bundles_resp, exp_resp);
  endtask

  task automatic step_cycle();
    @(posedge ap_clk);
    #1;
    drive_inputs();
    @(negedge ap_clk);
    sample_and_check();
  endtask

  // Memory held off first, then drained until everything came back
  task automatic run_traffic_batch(input int low_cycles);
    mem_ready_nx = 1'b0;
    repeat (low_cycles) step_cycle();
    if (low_cycles > 0 && queued != 6) begin
      $display("Back-pressure did not hold the queue at 6 requests");
      errors++;
    end
    mem_ready_nx = 1'b1;
    while (setup_q.size() || bundles_q.size() || exp_q.size() || pend_due.size()) begin
      step_cycle();
    end
    repeat (2) step_cycle();
  endtask

  initial begin
    mem_request_t pkt;
    {descriptor_valid, mem_ready, mem_resp_valid, setup_done, bundles_done} = '0;
    {setup_req_valid, bundles_req_valid} = '0;
    {descriptor, setup_req, bundles_req, mem_resp} = '0;
    {desc_valid_nx, mem_ready_nx, setup_done_nx, bundles_done_nx, desc_nx} = '0;
    {exp_resp_valid, exp_resp, setup_granted, bundles_granted, have_last, last_id} = '0;
    {errors, cyc, queued} = '0;
    exp_desc = '0;
    areset_control = 1'b1;
    // Batch 0 setup only, batch 1 both, batch 2 both under back-pressure
    for (int i = 0; i < num_rows; i++) begin
      table_rows[i].req = (i < 4) ? 1'b0 : i[0];
      table_rows[i].cmd = (i % 3 == 2) ? cmd_write : cmd_read;
      table_rows[i].addr = $random(seed);
      table_rows[i].data = $random(seed);
      table_rows[i].batch = (i < 4) ? 0 : (i < 12) ? 1 : 2;
      table_rows[i].ready_low = (i < 12) ? 0 : 20;
    end
    repeat (5) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
    repeat (3) step_cycle();
    check_value("setup_grant", setup_grant, 1'b0);
    check_value("done_out", done_out, 1'b0);
    check_value("flush_out", flush_out, 1'b0);

    // ------------------------------
    // Descriptor staging
    // ------------------------------
    desc_valid_nx = 1'b1;
    desc_nx = {$random(seed), $random(seed), $random(seed)};
    exp_desc = desc_nx;
    for (int k = 0; k < 4; k++) begin
      step_cycle();
      desc_valid_nx = 1'b0;
      // Input moves on, the staged copy must keep the valid cycle's payload
      desc_nx = ~exp_desc;
      check_value("setup_descriptor_valid", setup_descriptor_valid, k == 2);
      check_value("bundles_descriptor_valid", bundles_descriptor_valid, k == 2);
      if (k == 2) begin
        check_value("setup_descriptor", setup_descriptor, exp_desc);
        check_value("bundles_descriptor", bundles_descriptor, exp_desc);
      end
    end

    // Table rows, id set opposite so the tagging is exercised
    for (int i = 0; i < num_rows; i++) begin
      pkt.cmd = table_rows[i].cmd;
      pkt.id = ~table_rows[i].req;
      pkt.address = table_rows[i].addr;
      pkt.data = table_rows[i].data;
      if (table_rows[i].req) bundles_q.push_back(pkt);
      else setup_q.push_back(pkt);
      if (i == num_rows - 1 || table_rows[i + 1].batch != table_rows[i].batch) begin
        run_traffic_batch(table_rows[i].ready_low);
      end
    end

    // ------------------------------
    // Done and flush hold
    // ------------------------------
    // One write parked in the queue keeps done low with setup_done high
    pkt.cmd = cmd_write;
    pkt.id = 1'b1;
    pkt.address = $random(seed);
    pkt.data = $random(seed);
    setup_q.push_back(pkt);
    mem_ready_nx = 1'b0;
    setup_done_nx = 1'b1;
    for (int k = 0; k < 20; k++) begin
      step_cycle();
      check_value("done_out", done_out, 1'b0);
      check_value("flush_out", flush_out, 1'b0);
    end
    // Queue drains in cycle 0, setup hold starts at 1, bundles hold at 4
    mem_ready_nx = 1'b1;
    for (int k = 0; k < 24; k++) begin
      if (k == 4) bundles_done_nx = 1'b1;
      step_cycle();
      check_value("done_out", done_out, k >= 18);
      check_value("flush_out", flush_out, k >= 21);
    end
    // Each output falls one cycle after its own done level
    setup_done_nx = 1'b0;
    step_cycle();
    check_value("done_out", done_out, 1'b1);
    step_cycle();
    check_value("done_out", done_out, 1'b0);
    check_value("flush_out", flush_out, 1'b1);
    bundles_done_nx = 1'b0;
    step_cycle();
    check_value("flush_out", flush_out, 1'b1);
    step_cycle();
    check_value("done_out", done_out, 1'b0);
    check_value("flush_out", flush_out, 1'b0);

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : kernel_control_tb

// File: project.f
+incdir+common
common/kernel_pkg.sv
hw/decode/descriptor_stage.sv
hw/execute/request_fifo.sv
hw/execute/request_arbiter.sv
hw/result/response_router.sv
hw/result/done_monitor.sv
hw/kernel_control.sv
verification/kernel_control_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module kernel_control_tb -f project.f

out=$(./obj_dir/Vkernel_control_tb)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi
